/* int_alu.f */
+incdir+verification
logic/alu_pkg.sv
logic/cond_eval.sv
logic/alu_adder.sv
logic/alu_logic_move.sv
logic/alu_cond_ops.sv
logic/alu_retire_stage.sv
logic/int_alu.sv
verification/int_alu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the int_alu testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module int_alu_tb \
    -f int_alu.f -o int_alu_sim; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/int_alu_sim; then
  echo "simulation run reported failure"
  exit 1
fi

exit 0

/* verification/alu_model.svh */
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

logic [31:0] lcg_state = 32'd25;

function automatic logic [15:0] rand16();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state[31:16]; // low bits of an lcg are weak
endfunction

function automatic word_t rand_word();
  return {rand16(), rand16(), rand16(), rand16()};
endfunction

function automatic flags_t rand_flags();
  logic [15:0] r;
  r = rand16();
  return flags_t'(r[5:0]);
endfunction

function automatic word_t narrow32(word_t x);
  return {32'h0, x[31:0]};
endfunction

function automatic logic writes_flags(op_t o);
  return (o == op_add) || (o == op_sub) || (o == op_and) ||
         (o == op_or) || (o == op_xor) || (o == op_xnor);
endfunction

function automatic logic model_cond(cond_t c, flags_t f);
  logic slt;
  slt = f.sf ^ f.of;
  case (c)
    cc_z:    return f.zf;
    cc_nz:   return !f.zf;
    cc_s:    return f.sf;
    cc_ns:   return !f.sf;
    cc_ugt:  return !f.cf && !f.zf;
    cc_ule:  return f.cf || f.zf;
    cc_uge:  return !f.cf;
    cc_ult:  return f.cf;
    cc_sgt:  return !slt && !f.zf;
    cc_sle:  return slt || f.zf;
    cc_sge:  return !slt;
    cc_slt:  return slt;
    cc_o:    return f.of;
    cc_no:   return !f.of;
    cc_p:    return f.pf;
    default: return 1'b1; // always
  endcase
endfunction

function automatic word_t model_result(op_t o, logic w, cond_t c, word_t x, word_t y,
                                       flags_t f);
  word_t r;
  logic t;
  t = model_cond(c, f);
  case (o)
    op_add:   r = x + y;
    op_sub:   r = x - y;
    op_and:   r = x & y;
    op_or:    r = x | y;
    op_xor:   r = x ^ y;
    op_xnor:  r = ~(x ^ y);
    op_mov:   r = y;
    op_zxt8:  return {56'h0, y[7:0]};
    op_zxt16: return {48'h0, y[15:0]};
    op_sxt8:  r = {{56{y[7]}}, y[7:0]};
    op_sxt16: r = {{48{y[15]}}, y[15:0]};
    op_sxt32: return {{32{y[31]}}, y[31:0]};
    op_cmov:  r = t ? y : x;
    op_cset:  return {63'h0, t};
    op_csand: return {63'h0, t & x[0]};
    op_csor:  return {63'h0, t | x[0]};
    op_lahf:  return {58'h0, f};
    default:  return '0;
  endcase
  return w ? narrow32(r) : r;
endfunction

function automatic flags_t model_flags(op_t o, logic w, word_t x, word_t y);
  flags_t f;
  word_t r;
  logic [32:0] s33;
  logic [4:0] nib;
  logic xs;
  logic ys;
  logic rs;
  r = model_result(o, w, cc_always, x, y, '0);
  xs = w ? x[31] : x[63];
  ys = w ? y[31] : y[63];
  rs = w ? r[31] : r[63];
  f = '0;
  if (o == op_add) begin
    s33 = {1'b0, x[31:0]} + {1'b0, y[31:0]};
    nib = {1'b0, x[3:0]} + {1'b0, y[3:0]};
    f.cf = w ? s33[32] : (r < x); // wrap means carry out
    f.of = (xs == ys) && (rs != xs);
    f.af = nib[4];
  end else if (o == op_sub) begin
    f.cf = w ? (x[31:0] < y[31:0]) : (x < y);
    f.of = (xs != ys) && (rs != xs);
    f.af = x[3:0] < y[3:0];
  end
  f.sf = rs;
  f.zf = w ? (r[31:0] == 32'h0) : (r == '0);
  f.pf = ~^r[7:0];
  return f;
endfunction

`endif

/* verification/int_alu_tb.sv */
module int_alu_tb;
  import alu_pkg::*;

  `include "alu_model.svh"

  localparam int timeout_cycles = 3000; // ~1400 cycles of traffic doubled and rounded up

  logic   clk;
  logic   rst;
  logic   op_valid;
  op_t    op;
  logic   word32;
  cond_t  cond;
  word_t  a;
  word_t  b;
  flags_t flags_in;
  logic   res_valid;
  word_t  result;
  flags_t flags_out;
  logic   flags_wr;

  // one-deep expected register
  logic   exp_valid;
  logic   exp_wr;
  word_t  exp_result;
  flags_t exp_flags;
  int     cycles = 0;

  int_alu UUT (
    .clk       (clk),
    .rst       (rst),
    .op_valid  (op_valid),
    .op        (op),
    .word32    (word32),
    .cond      (cond),
    .a         (a),
    .b         (b),
    .flags_in  (flags_in),
    .res_valid (res_valid),
    .result    (result),
    .flags_out (flags_out),
    .flags_wr  (flags_wr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_run();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic report_wrong_value(string name, word_t got, word_t want);
    $display("mismatch %s got %h expected %h", name, got, want);
    fail_run();
  endtask

  always @(posedge clk) begin
    if (rst) begin
      exp_valid  <= 1'b0;
      exp_wr     <= 1'b0;
      exp_result <= '0;
      exp_flags  <= '0;
    end else begin
      // capture the op on the inputs for the next edge
      exp_valid <= op_valid;
      exp_wr    <= op_valid && writes_flags(op);
      if (op_valid) begin
        exp_result <= model_result(op, word32, cond, a, b, flags_in);
        if (writes_flags(op)) begin
          exp_flags <= model_flags(op, word32, a, b);
        end
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) !(res_valid && !exp_valid))
    else begin
      $display("res_valid raised with no matching request");
      fail_run();
    end

  assert property (@(posedge clk) disable iff (rst) res_valid == exp_valid)
    else report_wrong_value("res_valid", 64'($sampled(res_valid)),
                            64'($sampled(exp_valid)));

  assert property (@(posedge clk) disable iff (rst) flags_wr == exp_wr)
    else report_wrong_value("flags_wr", 64'($sampled(flags_wr)), 64'($sampled(exp_wr)));

  assert property (@(posedge clk) disable iff (rst) result == exp_result)
    else report_wrong_value("result", $sampled(result), $sampled(exp_result));

  assert property (@(posedge clk) disable iff (rst) flags_out == exp_flags)
    else report_wrong_value("flags_out", 64'($sampled(flags_out)),
                            64'($sampled(exp_flags)));

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout after %0d cycles without finishing", cycles);
      fail_run();
    end
  end

  task automatic apply_op(op_t o, logic w, cond_t c, word_t x, word_t y, flags_t f);
    @(negedge clk);
    op_valid = 1'b1;
    op       = o;
    word32   = w;
    cond     = c;
    a        = x;
    b        = y;
    flags_in = f;
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(negedge clk);
      op_valid = 1'b0;
    end
  endtask

  initial begin
    word_t       ca [0:9];
    word_t       cb [0:9];
    op_t         lops [0:3];
    op_t         xops [0:5];
    op_t         cops [0:3];
    logic [15:0] r;
    logic [15:0] sel;
    word_t       x;

    rst      = 1'b1;
    op_valid = 1'b0;
    op       = op_add;
    word32   = 1'b0;
    cond     = cc_z;
    a        = '0;
    b        = '0;
    flags_in = '0;

    ca = '{64'h0, 64'hffff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000,
           64'hf, 64'h1, 64'h8000_0000, 64'h7fff_ffff, 64'h1234_5678_9abc_def0,
           64'hffff_ffff};
    cb = '{64'h0, 64'h1, 64'h1, 64'h8000_0000_0000_0000, 64'h1, 64'h2, 64'h1, 64'h1,
           64'h1234_5678_9abc_def0, 64'h1};
    lops = '{op_and, op_or, op_xor, op_xnor};
    xops = '{op_mov, op_zxt8, op_zxt16, op_sxt8, op_sxt16, op_sxt32};
    cops = '{op_cmov, op_cset, op_csand, op_csor};

    repeat (10) @(negedge clk);
    rst = 1'b0;
    idle(5); // outputs must stay at reset values

    // add/sub corners and random operands
    for (int i = 0; i < 10; i++) begin
      for (int w = 0; w < 2; w++) begin
        apply_op(op_add, w[0], cc_always, ca[i], cb[i], rand_flags());
        apply_op(op_sub, w[0], cc_always, ca[i], cb[i], rand_flags());
      end
    end
    for (int i = 0; i < 200; i++) begin
      r = rand16();
      apply_op(r[0] ? op_sub : op_add, r[1], cc_always, rand_word(), rand_word(),
               rand_flags());
    end
    idle(2);

    for (int j = 0; j < 4; j++) begin
      for (int i = 0; i < 30; i++) begin
        apply_op(lops[j], i[0], cc_always, rand_word(), rand_word(), rand_flags());
      end
    end
    x = rand_word();
    apply_op(op_xnor, 1'b0, cc_always, x, x, rand_flags()); // all ones
    apply_op(op_xnor, 1'b1, cc_always, x, x, rand_flags());
    idle(2);

    // extensions with top bits of each width set
    for (int j = 0; j < 6; j++) begin
      for (int i = 0; i < 25; i++) begin
        x = rand_word();
        if (i < 15) begin
          x = x | 64'h8000_0000_8000_8080;
        end
        apply_op(xops[j], i[0], cc_always, rand_word(), x, rand_flags());
      end
    end
    for (int i = 0; i < 20; i++) begin
      apply_op(op_lahf, i[0], cc_always, rand_word(), rand_word(), rand_flags());
    end
    idle(2);

    for (int k = 0; k < 16; k++) begin
      for (int j = 0; j < 4; j++) begin
        for (int i = 0; i < 4; i++) begin
          apply_op(cops[j], i[1], cond_t'(k[3:0]), rand_word(), rand_word(), rand_flags());
        end
      end
    end
    idle(2);

    // mixed traffic with random gaps
    for (int i = 0; i < 300; i++) begin
      r   = rand16();
      sel = r % 16'd17;
      apply_op(op_t'(sel[4:0]), r[8], cond_t'(r[12:9]), rand_word(), rand_word(),
               rand_flags());
      r = rand16();
      idle(int'(r % 16'd3));
    end

    idle(3);
    $display("sim passed");
    $finish;
  end

endmodule

/* logic/int_alu.sv */
module int_alu (
  input  logic            clk,
  input  logic            rst,
  input  logic            op_valid,
  input  alu_pkg::op_t    op,
  input  logic            word32,
  input  alu_pkg::cond_t  cond,
  input  alu_pkg::word_t  a,
  input  alu_pkg::word_t  b,
  input  alu_pkg::flags_t flags_in,
  output logic            res_valid,
  output alu_pkg::word_t  result,
  output alu_pkg::flags_t flags_out,
  output logic            flags_wr
);
  import alu_pkg::*;

  logic  cond_true;
  word_t sum;
  logic  carry;
  logic  ovf;
  logic  aux;
  word_t lm_result;
  word_t cc_result;

  cond_eval u_cond_eval (
    .flags     (flags_in),
    .cond      (cond),
    .cond_true (cond_true)
  );

  alu_adder u_adder (
    .a      (a),
    .b      (b),
    .sub    (op == op_sub),
    .word32 (word32),
    .sum    (sum),
    .carry  (carry),
    .ovf    (ovf),
    .aux    (aux)
  );

  alu_logic_move u_logic_move (
    .op        (op),
    .word32    (word32),
    .a         (a),
    .b         (b),
    .lm_result (lm_result)
  );

  alu_cond_ops u_cond_ops (
    .op        (op),
    .word32    (word32),
    .cond_true (cond_true),
    .a         (a),
    .b         (b),
    .cc_result (cc_result)
  );

  alu_retire_stage u_retire (
    .clk       (clk),
    .rst       (rst),
    .op_valid  (op_valid),
    .op        (op),
    .word32    (word32),
    .flags_in  (flags_in),
    .sum       (sum),
    .carry     (carry),
    .ovf       (ovf),
    .aux       (aux),
    .lm_result (lm_result),
    .cc_result (cc_result),
    .res_valid (res_valid),
    .result    (result),
    .flags_out (flags_out),
    .flags_wr  (flags_wr)
  );

endmodule

/* logic/alu_retire_stage.sv */
module alu_retire_stage (
  input  logic            clk,
  input  logic            rst,
  input  logic            op_valid,
  input  alu_pkg::op_t    op,
  input  logic            word32,
  input  alu_pkg::flags_t flags_in,
  input  alu_pkg::word_t  sum,
  input  logic            carry,
  input  logic            ovf,
  input  logic            aux,
  input  alu_pkg::word_t  lm_result,
  input  alu_pkg::word_t  cc_result,
  output logic            res_valid,
  output alu_pkg::word_t  result,
  output alu_pkg::flags_t flags_out,
  output logic            flags_wr
);
  import alu_pkg::*;

  word_t  next_result;
  flags_t next_flags;
  logic   is_arith;
  logic   wr_now;     // flag write for the op on the inputs

  always_comb begin
    case (op)
      op_add, op_sub: begin
        next_result = sum;
      end
      op_and, op_or, op_xor, op_xnor, op_mov,
      op_zxt8, op_zxt16, op_sxt8, op_sxt16, op_sxt32: begin
        next_result = lm_result;
      end
      op_cmov, op_cset, op_csand, op_csor: begin
        next_result = cc_result;
      end
      op_lahf: begin
        next_result = {{(data_w-flags_w){1'b0}}, flags_in};
      end
      default: begin
        next_result = '0;
      end
    endcase
  end

  assign is_arith = (op == op_add) || (op == op_sub);
  assign wr_now   = op_valid && sets_flags(op);

  // logic ops leave cf/of/af clear
  always_comb begin
    next_flags.cf = is_arith & carry;
    next_flags.of = is_arith & ovf;
    next_flags.af = is_arith & aux;
    if (word32) begin
      next_flags.sf = next_result[half_w-1];
      next_flags.zf = (next_result[half_w-1:0] == '0);
    end else begin
      next_flags.sf = next_result[data_w-1];
      next_flags.zf = (next_result == '0);
    end
    next_flags.pf = ~^next_result[byte_w-1:0]; // even parity
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      flags_wr  <= 1'b0;
      result    <= '0;
      flags_out <= '0;
    end else begin
      res_valid <= op_valid;
      flags_wr  <= wr_now;
      if (op_valid) begin
        result <= next_result;
      end
      if (wr_now) begin
        flags_out <= next_flags; // held otherwise
      end
    end
  end

endmodule

/* logic/alu_cond_ops.sv */
module alu_cond_ops (
  input  alu_pkg::op_t   op,
  input  logic           word32,
  input  logic           cond_true,
  input  alu_pkg::word_t a,
  input  alu_pkg::word_t b,
  output alu_pkg::word_t cc_result
);
  import alu_pkg::*;

  word_t picked;  // cmov choice
  logic  bit0;    // single-bit result of set/and/or

  assign picked = cond_true ? b : a;

  always_comb begin
    case (op)
      op_csand: bit0 = cond_true & a[0];
      op_csor:  bit0 = cond_true | a[0];
      default:  bit0 = cond_true;
    endcase
  end

  always_comb begin
    case (op)
      op_cmov: begin
        if (word32) begin
          cc_result = {{(data_w-half_w){1'b0}}, picked[half_w-1:0]};
        end else begin
          cc_result = picked;
        end
      end
      op_cset, op_csand, op_csor: begin
        cc_result = {{(data_w-1){1'b0}}, bit0};
      end
      default: begin
        cc_result = '0;
      end
    endcase
  end

endmodule

/* logic/alu_logic_move.sv */
module alu_logic_move (
  input  alu_pkg::op_t   op,
  input  logic           word32,
  input  alu_pkg::word_t a,
  input  alu_pkg::word_t b,
  output alu_pkg::word_t lm_result
);
  import alu_pkg::*;

  word_t raw;     // full width value before 32-bit zeroing
  logic  narrow;  // op honours word32

  always_comb begin
    raw    = '0;
    narrow = 1'b0;
    case (op)
      op_and: begin
        raw    = a & b;
        narrow = word32;
      end
      op_or: begin
        raw    = a | b;
        narrow = word32;
      end
      op_xor: begin
        raw    = a ^ b;
        narrow = word32;
      end
      op_xnor: begin
        raw    = ~(a ^ b);
        narrow = word32;
      end
      op_mov: begin
        raw    = b;
        narrow = word32;
      end
      op_zxt8: begin
        raw = {{(data_w-byte_w){1'b0}}, b[byte_w-1:0]};
      end
      op_zxt16: begin
        raw = {{(data_w-short_w){1'b0}}, b[short_w-1:0]};
      end
      // 32-bit form is the 64-bit one with the upper half cleared
      op_sxt8: begin
        raw    = {{(data_w-byte_w){b[byte_w-1]}}, b[byte_w-1:0]};
        narrow = word32;
      end
      op_sxt16: begin
        raw    = {{(data_w-short_w){b[short_w-1]}}, b[short_w-1:0]};
        narrow = word32;
      end
      op_sxt32: begin
        raw = {{(data_w-half_w){b[half_w-1]}}, b[half_w-1:0]};
      end
      default: begin
        raw = '0; // not a logic/move op
      end
    endcase
  end

  always_comb begin
    if (narrow) begin
      lm_result = {{(data_w-half_w){1'b0}}, raw[half_w-1:0]};
    end else begin
      lm_result = raw;
    end
  end

endmodule

/* logic/alu_adder.sv */
module alu_adder (
  input  alu_pkg::word_t a,
  input  alu_pkg::word_t b,
  input  logic           sub,
  input  logic           word32,
  output alu_pkg::word_t sum,
  output logic           carry,
  output logic           ovf,
  output logic           aux
);
  import alu_pkg::*;

  word_t           b_eff;
  logic [data_w:0] full;   // top bit is the 64-bit carry out
  logic            cin_4;
  logic            cin_31;
  logic            cin_32;
  logic            cin_63;
  logic            cout;

  assign b_eff = sub ? ~b : b;
  assign full  = {1'b0, a} + {1'b0, b_eff} + {{data_w{1'b0}}, sub};

  // carry into a bit is sum ^ a ^ b at that bit
  assign cin_4  = full[4] ^ a[4] ^ b_eff[4];
  assign cin_31 = full[half_w-1] ^ a[half_w-1] ^ b_eff[half_w-1];
  assign cin_32 = full[half_w] ^ a[half_w] ^ b_eff[half_w];
  assign cin_63 = full[data_w-1] ^ a[data_w-1] ^ b_eff[data_w-1];

  assign cout = word32 ? cin_32 : full[data_w];

  always_comb begin
    if (word32) begin
      ovf = cin_31 ^ cin_32;
    end else begin
      ovf = cin_63 ^ full[data_w];
    end
  end

  // subtract reports borrow as inverted carry
  assign carry = cout ^ sub;
  assign aux   = cin_4 ^ sub;

  always_comb begin
    if (word32) begin
      sum = {{(data_w-half_w){1'b0}}, full[half_w-1:0]};
    end else begin
      sum = full[data_w-1:0];
    end
  end

endmodule

/* logic/cond_eval.sv */
module cond_eval (
  input  alu_pkg::flags_t flags,
  input  alu_pkg::cond_t  cond,
  output logic            cond_true
);
  import alu_pkg::*;

  logic lt; // signed less-than

  assign lt = flags.sf ^ flags.of;

  always_comb begin
    cond_true = 1'b1;
    case (cond)
      cc_z:      cond_true = flags.zf;
      cc_nz:     cond_true = ~flags.zf;
      cc_s:      cond_true = flags.sf;
      cc_ns:     cond_true = ~flags.sf;
      // cf holds the borrow after a compare
      cc_ugt:    cond_true = ~flags.cf & ~flags.zf;
      cc_ule:    cond_true = flags.cf | flags.zf;
      cc_uge:    cond_true = ~flags.cf;
      cc_ult:    cond_true = flags.cf;
      cc_sgt:    cond_true = ~lt & ~flags.zf;
      cc_sle:    cond_true = lt | flags.zf;
      cc_sge:    cond_true = ~lt;
      cc_slt:    cond_true = lt;
      cc_o:      cond_true = flags.of;
      cc_no:     cond_true = ~flags.of;
      cc_p:      cond_true = flags.pf;
      cc_always: cond_true = 1'b1;
    endcase
  end

endmodule

/* logic/alu_pkg.sv */
package alu_pkg;

  localparam int data_w  = 64;
  localparam int half_w  = data_w / 2;
  localparam int short_w = 16;
  localparam int byte_w  = 8;

  typedef logic [data_w-1:0] word_t;

  typedef enum logic [4:0] {
    op_add   = 5'd0,
    op_sub   = 5'd1,
    op_and   = 5'd2,
    op_or    = 5'd3,
    op_xor   = 5'd4,
    op_xnor  = 5'd5,
    op_mov   = 5'd6,
    op_zxt8  = 5'd7,
    op_zxt16 = 5'd8,
    op_sxt8  = 5'd9,
    op_sxt16 = 5'd10,
    op_sxt32 = 5'd11,
    op_cmov  = 5'd12,
    op_cset  = 5'd13,
    op_csand = 5'd14,
    op_csor  = 5'd15,
    op_lahf  = 5'd16
  } op_t;

  // most odd codes invert the even code just below them
  typedef enum logic [3:0] {
    cc_z      = 4'd0,
    cc_nz     = 4'd1,
    cc_s      = 4'd2,
    cc_ns     = 4'd3,
    cc_ugt    = 4'd4,
    cc_ule    = 4'd5,
    cc_uge    = 4'd6,
    cc_ult    = 4'd7,
    cc_sgt    = 4'd8,
    cc_sle    = 4'd9,
    cc_sge    = 4'd10,
    cc_slt    = 4'd11,
    cc_o      = 4'd12,
    cc_no     = 4'd13,
    cc_p      = 4'd14,
    cc_always = 4'd15
  } cond_t;

  typedef struct packed {
    logic cf;
    logic of;
    logic af;
    logic sf;
    logic zf;
    logic pf;
  } flags_t;

  localparam int flags_w = $bits(flags_t);

  function automatic logic sets_flags(op_t op);
    case (op)
      op_add, op_sub, op_and, op_or, op_xor, op_xnor: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage
